//--- verilog/ipdc_pkg.sv
package ipdc_pkg;

	// ----------------------------------------
	// image and window geometry
	// ----------------------------------------
	localparam int IMG_DIM    = 8;
	localparam int IMG_PIXELS = IMG_DIM * IMG_DIM;
	localparam int WIN_DIM    = 4;
	localparam int WIN_BEATS  = WIN_DIM * WIN_DIM;
	localparam int ADDR_W     = $clog2(IMG_PIXELS);

	// channel and pixel widths
	localparam int CH_W  = 8;
	localparam int PIX_W = 3 * CH_W;

	// last origin row or column that still moves on a shift
	localparam int SHIFT_LIMIT   = 3;
	// row 2, column 2
	localparam int ORIGIN_CENTER = 18;
	// 128 offset, already scaled by 8
	localparam int CONV_BIAS     = 1024;

	// ----------------------------------------
	// command and beat encodings
	// ----------------------------------------
	typedef enum logic [2:0] {
		OP_LOAD    = 3'd0,
		OP_RIGHT   = 3'd1,
		OP_DOWN    = 3'd2,
		OP_DEFAULT = 3'd3,
		OP_CENTER  = 3'd4,
		OP_MEDIAN  = 3'd5,
		OP_YCC     = 3'd6,
		OP_RGB     = 3'd7
	} op_mode_e;

	// none must stay zero, reset values rely on it
	typedef enum logic [1:0] {
		BEAT_NONE  = 2'd0,
		BEAT_PIXEL = 2'd1,
		BEAT_DONE  = 2'd2
	} beat_kind_e;

	// ----------------------------------------
	// pixel views, first channel in the low byte
	// ----------------------------------------
	typedef struct packed {
		logic [CH_W-1:0] b;
		logic [CH_W-1:0] g;
		logic [CH_W-1:0] r;
	} rgb_s;

	typedef struct packed {
		logic [CH_W-1:0] cr;
		logic [CH_W-1:0] cb;
		logic [CH_W-1:0] y;
	} ycc_s;

	// output word, read as rgb or ycbcr depending on the mode
	typedef union packed {
		rgb_s rgb;
		ycc_s ycc;
	} pixel_u;

	// ctrl to image buffer
	typedef struct packed {
		beat_kind_e        kind;
		logic              ycc;
		logic [ADDR_W-1:0] addr;
	} fetch_req_s;

	// image buffer to converter
	typedef struct packed {
		beat_kind_e kind;
		logic       ycc;
		rgb_s       pix;
	} pix_beat_s;

endpackage

//--- verilog/ipdc_ctrl.sv
`timescale 1ns/1ps

module ipdc_ctrl (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_op_valid,
	input  ipdc_pkg::op_mode_e          i_op_mode,
	input  logic                        i_in_valid,
	input  ipdc_pkg::rgb_s              i_in_data,
	output logic                        o_in_ready,
	output logic                        o_wr_en,
	output logic [ipdc_pkg::ADDR_W-1:0] o_wr_addr,
	output ipdc_pkg::rgb_s              o_wr_data,
	output ipdc_pkg::fetch_req_s        o_req
);
	import ipdc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WIN
	} state_e;

	state_e                           state;
	logic [ADDR_W-1:0]                origin;
	logic                             ycc_mode;
	logic [ADDR_W-1:0]                load_cnt;
	logic [$clog2(WIN_BEATS)-1:0]     win_cnt;
	logic                             done_pend;
	logic                             op_accept;
	logic                             pix_accept;
	logic                             load_last;
	logic                             win_last;
	logic [$clog2(IMG_DIM)-1:0]       org_col;
	logic [ADDR_W-$clog2(IMG_DIM)-1:0] org_row;
	logic [ADDR_W-1:0]                win_addr;
	fetch_req_s                       req_next;

	// ----------------------------------------
	// handshake and load write port
	// ----------------------------------------
	// ready drops only while a window is being fetched
	assign o_in_ready = (state != ST_WIN);
	assign op_accept  = i_op_valid && o_in_ready && (state == ST_IDLE);
	assign pix_accept = i_in_valid && (state == ST_LOAD);
	assign load_last  = (load_cnt == ADDR_W'(IMG_PIXELS - 1));
	assign win_last   = (win_cnt == $bits(win_cnt)'(WIN_BEATS - 1));

	// pixels go straight to the buffer in arrival order
	assign o_wr_en   = pix_accept;
	assign o_wr_addr = load_cnt;
	assign o_wr_data = i_in_data;

	// origin split into column and row
	assign org_col = origin[$clog2(IMG_DIM)-1:0];
	assign org_row = origin[ADDR_W-1:$clog2(IMG_DIM)];

	// beat k reads origin + (k / 4) rows + (k % 4) columns
	assign win_addr = origin + ADDR_W'((win_cnt / WIN_DIM) * IMG_DIM)
		+ ADDR_W'(win_cnt % WIN_DIM);

	// ----------------------------------------
	// fsm, origin and counters
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= ST_IDLE;
			origin    <= '0;
			ycc_mode  <= 1'b0;
			load_cnt  <= '0;
			win_cnt   <= '0;
			done_pend <= 1'b0;
		end else begin
			// one-shot, only held for a single cycle
			done_pend <= 1'b0;
			case (state)
			ST_IDLE: begin
				if (op_accept) begin
					case (i_op_mode)
					OP_LOAD: begin
						load_cnt <= '0;
						state    <= ST_LOAD;
					end
					OP_RIGHT: begin
						// clamp once the window touches the right edge
						if (org_col <= SHIFT_LIMIT)
							origin <= origin + 1'b1;
						win_cnt <= '0;
						state   <= ST_WIN;
					end
					OP_DOWN: begin
						if (org_row <= SHIFT_LIMIT)
							origin <= origin + ADDR_W'(IMG_DIM);
						win_cnt <= '0;
						state   <= ST_WIN;
					end
					OP_DEFAULT: begin
						origin  <= '0;
						win_cnt <= '0;
						state   <= ST_WIN;
					end
					OP_CENTER: begin
						origin  <= ADDR_W'(ORIGIN_CENTER);
						win_cnt <= '0;
						state   <= ST_WIN;
					end
					OP_YCC: begin
						ycc_mode  <= 1'b1;
						done_pend <= 1'b1;
					end
					OP_RGB: begin
						ycc_mode  <= 1'b0;
						done_pend <= 1'b1;
					end
					// median leaves the image alone, just acknowledge
					default: done_pend <= 1'b1;
					endcase
				end
			end
			ST_LOAD: begin
				if (pix_accept) begin
					load_cnt <= load_cnt + 1'b1;
					if (load_last) begin
						done_pend <= 1'b1;
						state     <= ST_IDLE;
					end
				end
			end
			ST_WIN: begin
				win_cnt <= win_cnt + 1'b1;
				if (win_last)
					state <= ST_IDLE;
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// fetch request, one per cycle
	// ----------------------------------------
	always_comb begin
		req_next      = '0;
		req_next.kind = BEAT_NONE;
		req_next.ycc  = ycc_mode;
		if (state == ST_WIN) begin
			req_next.kind = BEAT_PIXEL;
			req_next.addr = win_addr;
		end else if (done_pend) begin
			req_next.kind = BEAT_DONE;
		end
	end

	// registered, so an accepted event shows up a cycle later
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_req <= '0;
		else
			o_req <= req_next;
	end

endmodule

//--- verilog/ipdc_img_buf.sv
`timescale 1ns/1ps

module ipdc_img_buf (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_wr_en,
	input  logic [ipdc_pkg::ADDR_W-1:0] i_wr_addr,
	input  ipdc_pkg::rgb_s              i_wr_data,
	input  ipdc_pkg::fetch_req_s        i_req,
	output ipdc_pkg::pix_beat_s         o_beat
);
	import ipdc_pkg::*;

	// one entry per image pixel, row major
	rgb_s pix_mem [IMG_PIXELS];

	// ----------------------------------------
	// load write port
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < IMG_PIXELS; i++) begin
				pix_mem[i] <= '0;
			end
		end else if (i_wr_en) begin
			pix_mem[i_wr_addr] <= i_wr_data;
		end
	end

	// ----------------------------------------
	// registered read, tag follows the data
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_beat <= '0;
		end else begin
			o_beat.kind <= i_req.kind;
			o_beat.ycc  <= i_req.ycc;
			// only pixel beats carry data
			if (i_req.kind == BEAT_PIXEL)
				o_beat.pix <= pix_mem[i_req.addr];
			else
				o_beat.pix <= '0;
		end
	end

endmodule

//--- verilog/ipdc_color_conv.sv
`timescale 1ns/1ps

module ipdc_color_conv (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  ipdc_pkg::pix_beat_s i_beat,
	output logic                o_out_valid,
	output ipdc_pkg::pixel_u    o_out_data
);
	import ipdc_pkg::*;

	// channels widened to hold sums at 8x scale
	logic [CH_W+3:0] r_ext;
	logic [CH_W+3:0] g_ext;
	logic [CH_W+3:0] b_ext;
	logic [CH_W+3:0] y_sum;
	logic [CH_W+3:0] cb_sum;
	logic [CH_W+3:0] cr_sum;
	pixel_u          conv_word;

	// drop 3 fraction bits, round half up on bit 2, clip at 255
	function automatic logic [CH_W-1:0] round_sat(input logic [CH_W+3:0] sum);
		logic [CH_W:0] q;
		q = sum[CH_W+3:3] + (CH_W+1)'(sum[2]);
		if (q[CH_W])
			return '1;
		return q[CH_W-1:0];
	endfunction

	assign r_ext = (CH_W+4)'(i_beat.pix.r);
	assign g_ext = (CH_W+4)'(i_beat.pix.g);
	assign b_ext = (CH_W+4)'(i_beat.pix.b);

	// ----------------------------------------
	// shift-and-add coefficients
	// ----------------------------------------
	// y = 0.25r + 0.5g + 0.125g
	assign y_sum  = (r_ext << 1) + (g_ext << 2) + g_ext;
	// cb = 128 + 0.5b - 0.125r - 0.25g
	assign cb_sum = (CH_W+4)'(CONV_BIAS) + (b_ext << 2) - r_ext - (g_ext << 1);
	// cr = 128 + 0.5r - 0.25g - 0.125g - 0.125b
	assign cr_sum = (CH_W+4)'(CONV_BIAS) + (r_ext << 2) - (g_ext << 1)
		- g_ext - b_ext;

	// pick the view, done and idle beats give zero
	always_comb begin
		conv_word = '0;
		if (i_beat.kind == BEAT_PIXEL) begin
			if (i_beat.ycc) begin
				conv_word.ycc.y  = round_sat(y_sum);
				conv_word.ycc.cb = round_sat(cb_sum);
				conv_word.ycc.cr = round_sat(cr_sum);
			end else begin
				conv_word.rgb = i_beat.pix;
			end
		end
	end

	// ----------------------------------------
	// output register
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_out_data  <= '0;
		end else begin
			o_out_valid <= (i_beat.kind != BEAT_NONE);
			o_out_data  <= conv_word;
		end
	end

endmodule

//--- verilog/ipdc_top.sv
`timescale 1ns/1ps

module ipdc_top (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_op_valid,
	input  ipdc_pkg::op_mode_e         i_op_mode,
	input  logic                       i_in_valid,
	input  logic [ipdc_pkg::PIX_W-1:0] i_in_data,
	output logic                       o_in_ready,
	output logic                       o_out_valid,
	output logic [ipdc_pkg::PIX_W-1:0] o_out_data
);
	import ipdc_pkg::*;

	// load write port
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	rgb_s              wr_data;
	// pipeline between stages
	fetch_req_s        req;
	pix_beat_s         beat;

	// ----------------------------------------
	// control, buffer, converter
	// ----------------------------------------
	ipdc_ctrl u_ctrl (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_op_valid (i_op_valid),
		.i_op_mode  (i_op_mode),
		.i_in_valid (i_in_valid),
		.i_in_data  (i_in_data),
		.o_in_ready (o_in_ready),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.o_wr_data  (wr_data),
		.o_req      (req)
	);

	ipdc_img_buf u_buf (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_req     (req),
		.o_beat    (beat)
	);

	// output word leaves as a flat vector
	ipdc_color_conv u_conv (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_beat      (beat),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	// 4 ns period
	localparam int HALF_PERIOD = 2;
	localparam int RST_CYCLES  = 4;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	// release on a falling edge, away from the active edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

//--- tb/tb_ipdc.sv
`timescale 1ns/1ps

module tb_ipdc;
	import ipdc_pkg::*;

	localparam int CYCLE_LIMIT = 2000;
	// beat due 3 edges after acceptance, bit n means n edges later
	localparam logic [23:0] DONE_DUE = 24'h000008;
	// 16 back to back beats, bits 3 to 18
	localparam logic [23:0] WIN_DUE  = 24'h07FFF8;
	// forced pixels, both inside the default window
	localparam logic [ADDR_W-1:0] BLUE_ADDR = 6'd9;
	localparam logic [ADDR_W-1:0] RED_ADDR  = 6'd18;

	logic             i_clk;
	logic             i_rst_n;
	logic             i_op_valid;
	op_mode_e         i_op_mode;
	logic             i_in_valid;
	logic [PIX_W-1:0] i_in_data;
	logic             o_in_ready;
	logic             o_out_valid;
	logic [PIX_W-1:0] o_out_data;

	// reference model state
	rgb_s             model_img [IMG_PIXELS];
	int               org_row;
	int               org_col;
	bit               model_ycc;
	logic [PIX_W-1:0] exp_q [$];
	logic [PIX_W-1:0] exp_word;
	logic [23:0]      due;
	logic [23:0]      due_next;
	logic [WIN_BEATS-1:0] busy;
	logic [WIN_BEATS-1:0] busy_next;
	int               pix_cnt;
	int               cycle_cnt;
	integer           seed = 40782;
	string            test_name = "reset";

	tb_clk_gen u_clk_gen (
		.o_clk   (i_clk),
		.o_rst_n (i_rst_n)
	);

	ipdc_top DUT (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// divide by 8, half up on bit 2, clip at 255
	function automatic logic [CH_W-1:0] scale_down(input int s);
		int q;
		q = s / 8 + (s / 4) % 2;
		if (q > 255)
			q = 255;
		return q[CH_W-1:0];
	endfunction

	function automatic logic [PIX_W-1:0] ycbcr_of(input rgb_s p);
		int r;
		int g;
		int b;
		r = int'(p.r);
		g = int'(p.g);
		b = int'(p.b);
		// y low byte, then cb, cr on top
		return {scale_down(CONV_BIAS + 4 * r - 3 * g - b),
			scale_down(CONV_BIAS + 4 * b - r - 2 * g),
			scale_down(2 * r + 5 * g)};
	endfunction

	// ----------------------------------------
	// expected traffic
	// ----------------------------------------
	task automatic expect_window();
		logic [ADDR_W-1:0] a;
		for (int k = 0; k < WIN_BEATS; k++) begin
			a = ADDR_W'((org_row + k / WIN_DIM) * IMG_DIM + org_col + k % WIN_DIM);
			if (model_ycc)
				exp_q.push_back(ycbcr_of(model_img[a]));
			else
				exp_q.push_back(model_img[a]);
		end
	endtask

	// called on a falling edge, returns one falling edge after acceptance
	task automatic issue_op(input op_mode_e mode);
		while (!o_in_ready)
			@(negedge i_clk);
		i_op_valid = 1'b1;
		i_op_mode  = mode;
		@(negedge i_clk);
		i_op_valid = 1'b0;
	endtask

	task automatic run_window(input op_mode_e mode);
		case (mode)
		OP_RIGHT: begin
			if (org_col <= SHIFT_LIMIT)
				org_col++;
		end
		OP_DOWN: begin
			if (org_row <= SHIFT_LIMIT)
				org_row++;
		end
		OP_CENTER: begin
			org_row = ORIGIN_CENTER / IMG_DIM;
			org_col = ORIGIN_CENTER % IMG_DIM;
		end
		default: begin
			org_row = 0;
			org_col = 0;
		end
		endcase
		expect_window();
		issue_op(mode);
	endtask

	// mode ops only answer with a zero done beat
	task automatic run_mode(input op_mode_e mode);
		if (mode == OP_YCC)
			model_ycc = 1'b1;
		else if (mode == OP_RGB)
			model_ycc = 1'b0;
		exp_q.push_back('0);
		issue_op(mode);
	endtask

	task automatic load_image();
		logic [31:0] rnd;
		for (int i = 0; i < IMG_PIXELS; i++) begin
			rnd = $random(seed);
			model_img[ADDR_W'(i)] = rnd[PIX_W-1:0];
		end
		// full blue and full red push cb and cr into saturation
		model_img[BLUE_ADDR] = 24'hFF0000;
		model_img[RED_ADDR]  = 24'h0000FF;
		exp_q.push_back('0);
		issue_op(OP_LOAD);
		for (int i = 0; i < IMG_PIXELS; i++) begin
			// occasional idle gap
			if (($random(seed) & 3) == 0) begin
				i_in_valid = 1'b0;
				@(negedge i_clk);
			end
			i_in_valid = 1'b1;
			i_in_data  = model_img[ADDR_W'(i)];
			@(negedge i_clk);
		end
		i_in_valid = 1'b0;
	endtask

	// ----------------------------------------
	// timing model and checks
	// ----------------------------------------
	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			due     <= '0;
			busy    <= '0;
			pix_cnt <= 0;
		end else begin
			due_next  = due >> 1;
			busy_next = busy >> 1;
			if (i_op_valid && o_in_ready && i_op_mode != OP_LOAD) begin
				if (i_op_mode inside {OP_RIGHT, OP_DOWN, OP_DEFAULT, OP_CENTER}) begin
					due_next  = due_next | WIN_DUE;
					// ready low for the 16 edges after a window starts
					busy_next = '1;
				end else begin
					due_next = due_next | DONE_DUE;
				end
			end
			if (i_in_valid) begin
				// 64th pixel closes the load
				if (pix_cnt == IMG_PIXELS - 1)
					due_next = due_next | DONE_DUE;
				pix_cnt <= (pix_cnt == IMG_PIXELS - 1) ? 0 : pix_cnt + 1;
			end
			due  <= due_next;
			busy <= busy_next;
		end
	end

	beat_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid == due[0])
		else abort_run($sformatf("** Error [%s] o_out_valid expected %b actual %b",
			test_name, $sampled(due[0]), $sampled(o_out_valid)));

	ready_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_in_ready == !busy[0])
		else abort_run($sformatf("** Error [%s] o_in_ready expected %b actual %b",
			test_name, !$sampled(busy[0]), $sampled(o_in_ready)));

	// registered outputs, read before this edge updates them
	always @(posedge i_clk) begin
		if (i_rst_n && o_out_valid) begin
			beat_expected: assert (exp_q.size() != 0)
				else abort_run("a valid beat arrived while no beat was expected");
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				beat_value: assert (o_out_data == exp_word)
					else abort_run($sformatf(
						"** Error [%s] o_out_data expected %06h actual %06h",
						test_name, exp_word, o_out_data));
			end
		end
	end

	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		i_op_valid = 1'b0;
		i_op_mode  = OP_LOAD;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		cycle_cnt  = 0;
		org_row    = 0;
		org_col    = 0;
		model_ycc  = 1'b0;
		wait (i_rst_n == 1'b1);
		@(negedge i_clk);
		reset_state: assert (!o_out_valid && o_out_data == '0 && o_in_ready)
			else abort_run($sformatf(
				"** Error [%s] expected valid 0 data 000000 ready 1, actual %b %06h %b",
				test_name, o_out_valid, o_out_data, o_in_ready));

		test_name = "load and default window";
		load_image();
		run_window(OP_DEFAULT);

		test_name = "shift right and down";
		repeat (5) run_window(OP_RIGHT);
		repeat (5) run_window(OP_DOWN);

		test_name = "center and median";
		run_window(OP_CENTER);
		run_mode(OP_MEDIAN);
		run_window(OP_DEFAULT);

		test_name = "ycbcr and back to rgb";
		run_mode(OP_YCC);
		run_window(OP_DEFAULT);
		run_mode(OP_RGB);
		run_window(OP_DEFAULT);

		// drain the pipeline
		while (due != '0)
			@(negedge i_clk);
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d expected beats never arrived", exp_q.size()));
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- ipdc.f
verilog/ipdc_pkg.sv
verilog/ipdc_ctrl.sv
verilog/ipdc_img_buf.sv
verilog/ipdc_color_conv.sv
verilog/ipdc_top.sv
tb/tb_clk_gen.sv
tb/tb_ipdc.sv

//--- Makefile
# Verilator build and run of the ipdc testbench

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module tb_ipdc -f ipdc.f -o sim_ipdc
	./obj_dir/sim_ipdc

clean:
	rm -rf obj_dir
